//--- mem_pkg.sv
// shared types for the memory access unit
// width typedefs, operation enum and funct3 load/store codes

package mem_pkg;

    typedef logic [31:0] word_t;    // data word, store data and load result
    typedef logic [31:0] addr_t;    // byte address from the core
    typedef logic [3:0]  byte_en_t; // one write enable per lane
    typedef logic [2:0]  funct3_t;  // riscv width/sign field

    // funct3 codes shared by loads and stores
    localparam funct3_t f3_byte   = 3'd0; // lb / sb
    localparam funct3_t f3_half   = 3'd1; // lh / sh
    localparam funct3_t f3_word   = 3'd2; // lw / sw
    localparam funct3_t f3_byte_u = 3'd4; // lbu
    localparam funct3_t f3_half_u = 3'd5; // lhu

    typedef enum logic [1:0] {
        op_fetch, // instruction fetch, full word
        op_load,  // data load, width from funct3
        op_store  // data store, width from funct3
    } mem_op_t;

endpackage

//--- mem_req_if.sv
// request/result channel between the core port and the access handler
// four-phase req/ack with the payload held while req is high

`timescale 1ns/1ps

interface mem_req_if ();
    import mem_pkg::*;

    logic    req;    // request phase
    mem_op_t op;
    funct3_t funct3;
    addr_t   addr;   // byte address
    word_t   wdata;  // store data, lane 0 aligned
    logic    ack;    // response phase
    word_t   rdata;  // fetched word or extended load
    logic    err;    // misaligned or out of range

    modport requester (
        output req,
        output op,
        output funct3,
        output addr,
        output wdata,
        input  ack,
        input  rdata,
        input  err
    );

    modport handler (
        input  req,
        input  op,
        input  funct3,
        input  addr,
        input  wdata,
        output ack,
        output rdata,
        output err
    );

endinterface

//--- ram_bus_if.sv
// word-wide ram access channel with byte enables
// four-phase req/ack, word_addr width follows the ram size

`timescale 1ns/1ps

interface ram_bus_if #(
    parameter int ram_addr_bits = 8
) ();
    import mem_pkg::*;

    logic                     req;
    logic                     we;        // write when set, read otherwise
    byte_en_t                 be;        // lanes to write
    logic [ram_addr_bits-1:0] word_addr;
    word_t                    wdata;     // already shifted into its lanes
    logic                     ack;
    word_t                    rdata;     // whole word at word_addr

    modport master (
        output req,
        output we,
        output be,
        output word_addr,
        output wdata,
        input  ack,
        input  rdata
    );

    modport ram (
        input  req,
        input  we,
        input  be,
        input  word_addr,
        input  wdata,
        output ack,
        output rdata
    );

endinterface

//--- core_port.sv
// core-side port of the memory unit
// registers the core payload and relays req/ack one cycle each way

`timescale 1ns/1ps

module core_port (
    input  logic              clk,
    input  logic              nrst,
    input  logic              req,
    input  mem_pkg::mem_op_t  op,
    input  mem_pkg::funct3_t  funct3,
    input  mem_pkg::addr_t    addr,
    input  mem_pkg::word_t    wdata,
    output logic              ack,
    output mem_pkg::word_t    rdata,
    output logic              err,
    mem_req_if.requester      acc
);

    typedef enum logic {
        st_idle,
        st_busy
    } state_t;

    state_t state;
    logic   capture;

    assign capture = (state == st_idle) && req && !ack; // new core request

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state   <= st_idle;
            acc.req <= 1'b0;
            ack     <= 1'b0;
            rdata   <= '0;
            err     <= 1'b0;
        end else begin
            ack <= acc.ack; // both ack edges delayed by one cycle
            if (acc.ack && !ack) begin
                rdata <= acc.rdata;
                err   <= acc.err;
            end
            case (state)
                st_idle: begin
                    if (capture) begin
                        state <= st_busy;
                    end
                end
                st_busy: begin
                    acc.req <= req; // follows core req one cycle late
                    // internal ack gone and core ack falling now
                    if (ack && !acc.ack) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // payload stays fixed for the whole transaction
    always_ff @(posedge clk) begin
        if (capture) begin
            acc.op     <= op;
            acc.funct3 <= funct3;
            acc.addr   <= addr;
            acc.wdata  <= wdata;
        end
    end

    // a new request only after the previous ack has fallen
    assert property (@(posedge clk) disable iff (!nrst) $rose(req) |-> !ack)
        else $error("core req raised while ack still high");

    assert property (@(posedge clk) disable iff (!nrst)
        req && $past(req) |-> $stable({op, funct3, addr, wdata}))
        else $error("core payload changed during req");

endmodule

//--- access_handler.sv
// access handler FSM of the memory unit
// alignment and range check, store lane placement and byte enables,
// load lane extraction with sign or zero extension

`timescale 1ns/1ps

module access_handler #(
    parameter int ram_addr_bits = 8
) (
    input  logic       clk,
    input  logic       nrst,
    mem_req_if.handler acc,
    ram_bus_if.master  ram
);
    import mem_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_ram_wait,
        st_respond,
        st_release
    } state_t;

    state_t     state;
    logic [1:0] lane;
    logic       is_half;
    logic       is_word;
    logic       misaligned;
    logic       out_of_range;
    logic       accept;
    addr_t      addr_hi;
    byte_en_t   be_next;
    word_t      wdata_next;
    word_t      lane_data;
    word_t      load_data;
    word_t      resp_data;

    assign lane    = acc.addr[1:0];
    assign is_word = (acc.op == op_fetch) || acc.funct3[1]; // fetch is a word access
    assign is_half = (acc.op != op_fetch) && (acc.funct3[1:0] == 2'b01);

    assign misaligned   = (is_half && lane[0]) || (is_word && (lane != 2'b00));
    assign addr_hi      = acc.addr >> (ram_addr_bits + 2); // bits above the ram
    assign out_of_range = (addr_hi != '0);
    assign accept       = !misaligned && !out_of_range;

    always_comb begin
        if (is_word) begin
            be_next = 4'b1111;
        end else if (is_half) begin
            be_next = 4'b0011 << lane;
        end else begin
            be_next = 4'b0001 << lane;
        end
    end

    assign wdata_next = acc.wdata << {lane, 3'b000}; // move into addressed lane
    assign lane_data  = ram.rdata >> {lane, 3'b000}; // addressed lane down to bit 0

    always_comb begin
        case (acc.funct3)
            f3_byte:   load_data = {{24{lane_data[7]}}, lane_data[7:0]};
            f3_half:   load_data = {{16{lane_data[15]}}, lane_data[15:0]};
            f3_byte_u: load_data = {24'b0, lane_data[7:0]};
            f3_half_u: load_data = {16'b0, lane_data[15:0]};
            f3_word:   load_data = ram.rdata;
            default:   load_data = ram.rdata;
        endcase
    end

    always_comb begin
        case (acc.op)
            op_load:  resp_data = load_data;
            op_fetch: resp_data = ram.rdata; // instruction word as stored
            default:  resp_data = '0;        // stores return nothing
        endcase
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state   <= st_idle;
            acc.ack <= 1'b0;
            acc.err <= 1'b0;
            ram.req <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (acc.req && accept) begin
                        ram.req <= 1'b1;
                        state   <= st_ram_wait;
                    end else if (acc.req) begin
                        acc.ack <= 1'b1; // reject at once, ram untouched
                        acc.err <= 1'b1;
                        state   <= st_respond;
                    end
                end
                st_ram_wait: begin
                    if (ram.ack) begin
                        ram.req <= 1'b0;
                        acc.ack <= 1'b1;
                        state   <= st_respond;
                    end
                end
                st_respond: begin
                    if (!acc.req) begin
                        acc.ack <= 1'b0;
                        acc.err <= 1'b0;
                        state   <= st_release;
                    end
                end
                st_release: begin
                    // ram must finish its own phase 4 first
                    if (!ram.ack) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state == st_idle) && acc.req) begin
            ram.we        <= (acc.op == op_store);
            ram.be        <= (acc.op == op_store) ? be_next : 4'b0000;
            ram.word_addr <= acc.addr[ram_addr_bits+1:2];
            ram.wdata     <= wdata_next;
            acc.rdata     <= '0;
        end else if ((state == st_ram_wait) && ram.ack) begin
            acc.rdata <= resp_data;
        end
    end

endmodule

//--- data_ram.sv
// on-chip word ram with per-lane write enables
// ack follows req by one cycle, access done on the rising req

`timescale 1ns/1ps

module data_ram #(
    parameter int ram_addr_bits = 8
) (
    input  logic   clk,
    input  logic   nrst,
    ram_bus_if.ram bus
);
    import mem_pkg::*;

    localparam int words = 2 ** ram_addr_bits;

    word_t mem [words];
    logic  access;

    assign access = bus.req && !bus.ack; // first cycle of a request

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            bus.ack <= 1'b0;
        end else begin
            bus.ack <= bus.req;
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            if (bus.we) begin
                for (int i = 0; i < 4; i++) begin
                    if (bus.be[i]) begin
                        mem[bus.word_addr][8*i +: 8] <= bus.wdata[8*i +: 8];
                    end
                end
            end
            bus.rdata <= mem[bus.word_addr]; // old word on a write
        end
    end

    // master holds req until the ram has answered
    assert property (@(posedge clk) disable iff (!nrst) bus.req && !bus.ack |=> bus.req)
        else $error("ram req dropped before ack");

endmodule

//--- mem_sys_top.sv
// memory access unit top level
// core port, access handler and data ram joined by two handshake interfaces

`timescale 1ns/1ps

module mem_sys_top #(
    parameter int ram_addr_bits = 8
) (
    input  logic             clk,
    input  logic             nrst,
    input  logic             req,
    input  mem_pkg::mem_op_t op,
    input  mem_pkg::funct3_t funct3,
    input  mem_pkg::addr_t   addr,
    input  mem_pkg::word_t   wdata,
    output logic             ack,
    output mem_pkg::word_t   rdata,
    output logic             err
);

    mem_req_if i_acc_if ();

    ram_bus_if #(
        .ram_addr_bits(ram_addr_bits)
    ) i_ram_if ();

    core_port i_core_port (
        .clk    (clk),
        .nrst   (nrst),
        .req    (req),
        .op     (op),
        .funct3 (funct3),
        .addr   (addr),
        .wdata  (wdata),
        .ack    (ack),
        .rdata  (rdata),
        .err    (err),
        .acc    (i_acc_if.requester)
    );

    access_handler #(
        .ram_addr_bits(ram_addr_bits)
    ) i_access_handler (
        .clk  (clk),
        .nrst (nrst),
        .acc  (i_acc_if.handler),
        .ram  (i_ram_if.master)
    );

    data_ram #(
        .ram_addr_bits(ram_addr_bits)
    ) i_data_ram (
        .clk  (clk),
        .nrst (nrst),
        .bus  (i_ram_if.ram)
    );

endmodule

//--- tb_mem_sys.sv
// testbench for the memory access unit
// lfsr stimulus, byte-array reference model, compare task and handshake timeouts

`timescale 1ns/1ps

module tb_mem_sys;
    import mem_pkg::*;

    localparam int ram_addr_bits = 8;
    localparam int ram_bytes     = 4 << ram_addr_bits;
    localparam int max_wait      = 50; // cycles allowed per handshake phase

    logic    clk;
    logic    nrst;
    logic    req;
    mem_op_t op;
    funct3_t funct3;
    addr_t   addr;
    word_t   wdata;
    logic    ack;
    word_t   rdata;
    logic    err;

    logic [31:0] lfsr;
    logic [7:0]  model_mem [ram_bytes]; // byte-wide mirror of the ram
    word_t       got_data;
    logic        got_err;

    mem_sys_top #(
        .ram_addr_bits(ram_addr_bits)
    ) i_mem_sys_top (
        .clk    (clk),
        .nrst   (nrst),
        .req    (req),
        .op     (op),
        .funct3 (funct3),
        .addr   (addr),
        .wdata  (wdata),
        .ack    (ack),
        .rdata  (rdata),
        .err    (err)
    );

    always #4 clk = ~clk;

    // galois lfsr stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] value;
        logic        out_bit;
        value = '0;
        for (int i = 0; i < n; i++) begin
            out_bit = lfsr[0];
            lfsr    = {1'b0, lfsr[31:1]} ^ (out_bit ? 32'h8020_0003 : 32'h0);
            value   = {value[30:0], out_bit};
        end
        return value;
    endfunction

    task automatic stop_on_failure(input string reason);
        $display("%s", reason);
        $display("Regression failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            stop_on_failure($sformatf("[ERROR] %s expected %h actual %h",
                                      name, expected, actual));
        end
    endtask

    // misaligned or beyond the ram
    function automatic logic model_rejects(input mem_op_t m_op, input funct3_t f3,
                                           input addr_t a);
        logic is_word;
        logic is_half;
        is_word = (m_op == op_fetch) || (f3 == f3_word);
        is_half = (m_op != op_fetch) && ((f3 == f3_half) || (f3 == f3_half_u));
        return (is_word && (a[1:0] != 2'b00)) || (is_half && a[0]) ||
               (a >= addr_t'(ram_bytes));
    endfunction

    function automatic word_t model_word(input addr_t a);
        int base;
        base = int'(a & addr_t'(ram_bytes - 4));
        return {model_mem[base+3], model_mem[base+2], model_mem[base+1], model_mem[base]};
    endfunction

    function automatic word_t model_load(input mem_op_t m_op, input funct3_t f3,
                                         input addr_t a);
        word_t w;
        word_t lane;
        word_t result;
        w    = model_word(a);
        lane = w >> (8 * a[1:0]); // addressed byte down to bit 0
        case (f3)
            f3_byte:   result = {{24{lane[7]}}, lane[7:0]};
            f3_half:   result = {{16{lane[15]}}, lane[15:0]};
            f3_byte_u: result = {24'd0, lane[7:0]};
            f3_half_u: result = {16'd0, lane[15:0]};
            default:   result = w;
        endcase
        if (m_op == op_fetch) begin
            result = w;
        end
        return result;
    endfunction

    function automatic void model_store(input funct3_t f3, input addr_t a, input word_t d);
        int base;
        int nbytes;
        base   = int'(a & addr_t'(ram_bytes - 1));
        nbytes = (f3 == f3_word) ? 4 : ((f3 == f3_half) ? 2 : 1);
        for (int i = 0; i < nbytes; i++) begin
            model_mem[base+i] = d[8*i +: 8];
        end
    endfunction

    // one full four-phase transaction with a random core delay before req drops
    task automatic run_access(input mem_op_t a_op, input funct3_t f3, input addr_t a,
                              input word_t d);
        int waited;
        int hold;
        @(negedge clk);
        op     = a_op;
        funct3 = f3;
        addr   = a;
        wdata  = d;
        req    = 1'b1;
        waited = 0;
        while (ack !== 1'b1) begin
            @(negedge clk);
            waited++;
            if (waited > max_wait) begin
                stop_on_failure("ack did not rise after req was raised");
            end
        end
        got_data = rdata;
        got_err  = err;
        hold     = int'(rand_bits(2));
        repeat (hold) begin
            @(negedge clk);
            check_value("ack held while req high", 32'd1, {31'd0, ack});
        end
        req    = 1'b0;
        waited = 0;
        while (ack !== 1'b0) begin
            @(negedge clk);
            waited++;
            if (waited > max_wait) begin
                stop_on_failure("ack did not fall after req was dropped");
            end
        end
    endtask

    task automatic expect_access(input string name, input mem_op_t a_op, input funct3_t f3,
                                 input addr_t a, input word_t d);
        logic reject;
        reject = model_rejects(a_op, f3, a);
        run_access(a_op, f3, a, d);
        check_value({name, " err"}, {31'd0, reject}, {31'd0, got_err});
        if (!reject && (a_op == op_store)) begin
            model_store(f3, a, d);
        end else if (!reject) begin
            check_value({name, " rdata"}, model_load(a_op, f3, a), got_data);
        end
    endtask

    initial begin
        word_t   value;
        addr_t   base;
        addr_t   lane;
        addr_t   far;
        funct3_t f3;
        int      sel;
        clk    = 1'b0;
        nrst   = 1'b0;
        req    = 1'b0;
        op     = op_fetch;
        funct3 = f3_word;
        addr   = '0;
        wdata  = '0;
        lfsr   = 32'd44;
        repeat (5) @(negedge clk);
        nrst = 1'b1;
        @(negedge clk);
        check_value("reset ack", 32'd0, {31'd0, ack});
        check_value("reset rdata", 32'd0, rdata);
        check_value("reset err", 32'd0, {31'd0, err});

        // known contents everywhere before any load
        for (int w = 0; w < (1 << ram_addr_bits); w++) begin
            expect_access("fill sw", op_store, f3_word, addr_t'(w * 4), rand_bits(32));
        end

        for (int n = 0; n < 60; n++) begin
            base = rand_bits(ram_addr_bits) << 2;
            sel  = int'(rand_bits(2));
            if (sel == 0) begin
                f3   = f3_byte;
                lane = rand_bits(2);
            end else if (sel == 1) begin
                f3   = f3_half;
                lane = rand_bits(1) << 1;
            end else begin
                f3   = f3_word;
                lane = '0;
            end
            expect_access("random store", op_store, f3, base | lane, rand_bits(32));
            expect_access("store readback lw", op_load, f3_word, base, '0);
        end

        for (int n = 0; n < 12; n++) begin
            base = rand_bits(ram_addr_bits) << 2;
            for (int l = 0; l < 4; l++) begin
                expect_access("lb", op_load, f3_byte, base + addr_t'(l), '0);
                expect_access("lbu", op_load, f3_byte_u, base + addr_t'(l), '0);
            end
            for (int l = 0; l < 4; l += 2) begin
                expect_access("lh", op_load, f3_half, base + addr_t'(l), '0);
                expect_access("lhu", op_load, f3_half_u, base + addr_t'(l), '0);
            end
        end

        for (int n = 0; n < 20; n++) begin
            base  = rand_bits(ram_addr_bits) << 2;
            value = rand_bits(32);
            f3    = funct3_t'(rand_bits(3)); // fetch ignores funct3
            expect_access("fetch store", op_store, f3_word, base, value);
            expect_access("fetch", op_fetch, f3, base, '0);
            check_value("fetch word", value, got_data);
        end

        for (int n = 0; n < 20; n++) begin
            base  = rand_bits(ram_addr_bits) << 2;
            value = rand_bits(32);
            lane  = rand_bits(2);
            if (lane == '0) begin
                lane = addr_t'(3); // any nonzero lane is a bad word access
            end
            far = (rand_bits(32) | addr_t'(ram_bytes)) & ~addr_t'(3);
            expect_access("odd sh", op_store, f3_half, base | 1 | (rand_bits(1) << 1), value);
            expect_access("odd lh", op_load, f3_half, base | 1 | (rand_bits(1) << 1), '0);
            expect_access("odd lhu", op_load, f3_half_u, base | 1, '0);
            expect_access("misaligned sw", op_store, f3_word, base | lane, value);
            expect_access("misaligned lw", op_load, f3_word, base | lane, '0);
            expect_access("misaligned fetch", op_fetch, funct3_t'(rand_bits(3)),
                          base | lane, '0);
            expect_access("reject readback lw", op_load, f3_word, base, '0);
            expect_access("far sw", op_store, f3_word, far, value);
            expect_access("far sb", op_store, f3_byte, far | rand_bits(2), value);
            expect_access("far lw", op_load, f3_word, far, '0);
            expect_access("far readback lw", op_load, f3_word,
                          far & addr_t'(ram_bytes - 4), '0);
        end

        $display("Regression passed");
        $finish;
    end

endmodule

//--- mem_sys.f
mem_pkg.sv
mem_req_if.sv
ram_bus_if.sv
core_port.sv
access_handler.sv
data_ram.sv
mem_sys_top.sv
tb_mem_sys.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_mem_sys
FILELIST  ?= mem_sys.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Regression failed" $(LOG); then exit 1; fi
	@if ! grep -q "Regression passed" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
